/* all.f */
hw/fetch_pkg.sv
hw/instr_rom_cache.sv
hw/fetch_unit.sv
hw/fetch_top.sv
bench/fetch_clkgen.sv
bench/fetch_monitor.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

/* bench/fetch_chk.sv */
/*
 * Assertions bound into the fetch unit: cache command hold,
 * no stray c_done, stable output under decode stall
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_chk import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  cache_cmd_t       c_cmd,
    input  cache_cmd_t       active_cmd,
    input  wire logic [31:0] c_address,
    input  wire logic        c_done,
    input  wire logic        f2d_valid,
    input  f2d_type_t        f2d_type,
    input  wire logic [31:0] f2d_instr,
    input  wire logic [31:0] f2d_pc,
    input  wire logic        d2f_ready
);

    int fail_count = 0;

    // A command stays on the bus until the cache finishes it
    cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
        (c_cmd != CACHE_CMD_NONE) |=> c_done || ($stable(c_cmd) && $stable(c_address)))
    else begin
        fail_count++;
        $error("Cache command or address changed before c_done");
    end

    // The cache only finishes what was started
    done_when_active: assert property (@(posedge clk) disable iff (!rst_n)
        c_done |-> (active_cmd != CACHE_CMD_NONE))
    else begin
        fail_count++;
        $error("c_done rose while no cache command was active");
    end

    // A stalled word or fault is replayed unchanged
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (f2d_valid && !d2f_ready && f2d_type != F2D_TYPE_INTERRUPT_PENDING) |=>
        f2d_valid && $stable(f2d_instr) && $stable(f2d_pc) && $stable(f2d_type))
    else begin
        fail_count++;
        $error("Decode output changed while decode was stalled");
    end

endmodule

`default_nettype wire

/* bench/fetch_clkgen.sv */
/*
 * Testbench clock and reset: 20 ns clock, reset low for two cycles
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_clkgen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release lands just after an edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/fetch_monitor.sv */
/*
 * Decode-side monitor: predicts every item that decode takes,
 * counts items, interrupt items and value errors
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_monitor import fetch_pkg::*; #(
    parameter int unsigned ROM_WORDS    = 1024,
    parameter logic [31:0] RESET_VECTOR = 32'h0
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        f2d_valid,
    input  f2d_type_t        f2d_type,
    input  wire logic [31:0] f2d_instr,
    input  wire logic [31:0] f2d_pc,
    input  wire logic        d2f_ready,
    input  d2f_cmd_t         d2f_cmd,
    input  wire logic [31:0] d2f_branchtarget,
    output int               item_count,
    output int               intr_count,
    output int               error_count
);

    string       test_name = "reset";
    logic [31:0] exp_pc;
    logic        branch_pending;
    logic        branch_seq_seen;
    logic [31:0] branch_target;

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    // Word addresses below the ROM depth are backed by ROM
    function automatic logic in_rom(input logic [31:0] addr);
        return addr < ROM_WORDS * 4;
    endfunction

    //////////////////////////////
    // Sampling at the falling edge, where the cycle's values have settled
    always @(negedge clk) begin
        f2d_type_t exp_type;
        if (!rst_n) begin
            exp_pc          = RESET_VECTOR;
            branch_pending  = 1'b0;
            branch_seq_seen = 1'b0;
            item_count      = 0;
            intr_count      = 0;
            error_count     = 0;
        end else begin
            if (f2d_valid && d2f_ready && f2d_type == F2D_TYPE_INTERRUPT_PENDING) begin
                intr_count++;
            end else if (f2d_valid && d2f_ready) begin
                item_count++;
                // The fetch already in flight may still deliver one sequential item
                if (branch_pending && (f2d_pc == branch_target || branch_seq_seen)) begin
                    exp_pc         = branch_target;
                    branch_pending = 1'b0;
                end else if (branch_pending) begin
                    branch_seq_seen = 1'b1;
                end
                exp_type = in_rom(exp_pc) ? F2D_TYPE_INSTR : F2D_TYPE_ACCESS_FAULT;
                check_value("pc", exp_pc, f2d_pc);
                check_value("type", 32'(exp_type), 32'(f2d_type));
                if (exp_type == F2D_TYPE_INSTR) begin
                    check_value("instr", exp_pc ^ ROM_PATTERN, f2d_instr);
                end
                exp_pc = exp_pc + 32'd4;
            end
            // A branch taken with an item counts after that item
            if (d2f_ready && d2f_cmd == D2F_CMD_START_BRANCH) begin
                branch_pending  = 1'b1;
                branch_seq_seen = 1'b0;
                branch_target   = d2f_branchtarget;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/fetch_tb.sv */
/*
 * Fetch front end testbench: scenario table, stimulus loop,
 * xorshift ready pattern, timeout and final report
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    localparam int unsigned CACHE_LATENCY = 3;
    localparam int unsigned ROM_WORDS     = 1024;
    localparam logic [31:0] RESET_VECTOR  = 32'h0000_0080;
    localparam int          NUM_ROWS      = 6;

    //////////////////////////////
    // Scenario table, one column per field and one entry per test
    string       row_name   [NUM_ROWS] = '{"reset", "sequential", "branch",
                                           "flush", "interrupt", "debug_fault"};
    int          row_items  [NUM_ROWS] = '{2, 24, 10, 10, 4, 3};
    int          row_ready  [NUM_ROWS] = '{100, 50, 70, 60, 80, 100};
    d2f_cmd_t    row_cmd    [NUM_ROWS] = '{D2F_CMD_NONE, D2F_CMD_NONE, D2F_CMD_START_BRANCH,
                                           D2F_CMD_FLUSH, D2F_CMD_START_BRANCH,
                                           D2F_CMD_START_BRANCH};
    // The last target lies just beyond the ROM
    logic [31:0] row_target [NUM_ROWS] = '{32'h0, 32'h0, 32'h300, 32'h0, 32'h100,
                                           32'(ROM_WORDS * 4 + 32)};
    int          row_after  [NUM_ROWS] = '{0, 0, 3, 4, 0, 0};
    int          row_irq    [NUM_ROWS] = '{0, 0, 0, 0, 8, 0};
    logic        row_dbg    [NUM_ROWS] = '{0, 0, 0, 0, 1, 1};

    logic        clk, rst_n;
    logic [31:0] reset_vector;
    logic        interrupt_pending, dbg_mode, busy;
    logic        f2d_valid;
    f2d_type_t   f2d_type;
    logic [31:0] f2d_instr, f2d_pc;
    logic        d2f_ready;
    d2f_cmd_t    d2f_cmd;
    logic [31:0] d2f_branchtarget;
    int          item_count, intr_count, error_count;
    logic [31:0] rng;
    int          cycle_count = 0;

    fetch_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    fetch_top #(
        .CACHE_LATENCY (CACHE_LATENCY),
        .ROM_WORDS     (ROM_WORDS)
    ) u_fetch_top (
        .clk (clk), .rst_n (rst_n), .reset_vector (reset_vector),
        .interrupt_pending (interrupt_pending), .dbg_mode (dbg_mode), .busy (busy),
        .f2d_valid (f2d_valid), .f2d_type (f2d_type), .f2d_instr (f2d_instr),
        .f2d_pc (f2d_pc), .d2f_ready (d2f_ready), .d2f_cmd (d2f_cmd),
        .d2f_branchtarget (d2f_branchtarget)
    );

    fetch_monitor #(.ROM_WORDS(ROM_WORDS), .RESET_VECTOR(RESET_VECTOR)) u_monitor (
        .clk (clk), .rst_n (rst_n), .f2d_valid (f2d_valid), .f2d_type (f2d_type),
        .f2d_instr (f2d_instr), .f2d_pc (f2d_pc), .d2f_ready (d2f_ready),
        .d2f_cmd (d2f_cmd), .d2f_branchtarget (d2f_branchtarget),
        .item_count (item_count), .intr_count (intr_count), .error_count (error_count)
    );

    bind fetch_unit fetch_chk u_chk (
        .clk (clk), .rst_n (rst_n), .c_cmd (c_cmd), .active_cmd (active_cmd),
        .c_address (c_address), .c_done (c_done), .f2d_valid (f2d_valid),
        .f2d_type (f2d_type), .f2d_instr (f2d_instr), .f2d_pc (f2d_pc),
        .d2f_ready (d2f_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Generous bound: four times the stall-free time of every item, plus slack
    function automatic int timeout_limit();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            sum += row_items[i] * (CACHE_LATENCY + 2);
        end
        return sum * 4 + 200;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Debug mode drains the unit, then interrupts are offered while it is idle
    task automatic check_debug_idle(input int i);
        int waited;
        int items_before;
        int intr_before;
        waited = 0;
        next_cycle();
        dbg_mode  = 1'b1;
        d2f_ready = 1'b1;
        d2f_cmd   = D2F_CMD_NONE;
        while (busy && waited < CACHE_LATENCY + 2) begin
            next_cycle();
            waited++;
        end
        u_monitor.check_value("busy in debug mode", 32'd0, 32'(busy));
        items_before = item_count;
        intr_before  = intr_count;
        repeat (2 * (CACHE_LATENCY + 2)) next_cycle();
        u_monitor.check_value("items in debug mode", items_before, item_count);
        if (row_irq[i] > 0) begin
            next_cycle();
            interrupt_pending = 1'b1;
            repeat (row_irq[i] - 1) next_cycle();
            next_cycle();
            interrupt_pending = 1'b0;
            u_monitor.check_value("interrupt items", intr_before + row_irq[i], intr_count);
        end
    endtask

    task automatic run_row(input int i);
        int  start;
        logic sent;
        u_monitor.set_test(row_name[i]);
        if (row_dbg[i]) begin
            check_debug_idle(i);
        end
        start = item_count;
        sent  = (row_cmd[i] == D2F_CMD_NONE);
        while (item_count - start < row_items[i]) begin
            next_cycle();
            dbg_mode  = 1'b0;
            rng       = xorshift32(rng);
            d2f_ready = (rng % 100) < row_ready[i];
            d2f_cmd   = D2F_CMD_NONE;
            // Decode is ready when it sends a command, or the command would not count
            if (!sent && item_count - start >= row_after[i]) begin
                d2f_ready        = 1'b1;
                d2f_cmd          = row_cmd[i];
                d2f_branchtarget = row_target[i];
                sent             = 1'b1;
            end
        end
    endtask

    initial begin
        reset_vector      = RESET_VECTOR;
        interrupt_pending = 1'b0;
        dbg_mode          = 1'b0;
        d2f_ready         = 1'b0;
        d2f_cmd           = D2F_CMD_NONE;
        d2f_branchtarget  = 32'h0;
        rng               = 32'd83212;
        @(posedge rst_n);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        repeat (CACHE_LATENCY + 2) next_cycle();
        $display("Errors: %0d wrong values, %0d assertion failures",
                 error_count, u_fetch_top.u_fetch.u_chk.fail_count);
        if (error_count == 0 && u_fetch_top.u_fetch.u_chk.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit()) begin
            $display("Timeout: the scenarios did not finish within %0d cycles",
                     timeout_limit());
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_pkg.sv */
/*
 * Shared encodings of the fetch front end: cache commands and responses,
 * fetch-to-decode item types, decode-to-fetch commands and the ROM pattern
 */
`default_nettype none

package fetch_pkg;

    // Command from the fetch unit to the instruction cache
    typedef enum logic [1:0] {
        CACHE_CMD_NONE      = 2'd0,
        CACHE_CMD_EXECUTE   = 2'd1,
        CACHE_CMD_FLUSH_ALL = 2'd2
    } cache_cmd_t;

    // Response that comes back with c_done
    typedef enum logic [1:0] {
        CACHE_RESP_OK           = 2'd0,
        CACHE_RESP_ACCESS_FAULT = 2'd1
    } cache_resp_t;

    // Kind of item handed to decode
    typedef enum logic [1:0] {
        F2D_TYPE_INSTR             = 2'd0,
        F2D_TYPE_INTERRUPT_PENDING = 2'd1,
        F2D_TYPE_ACCESS_FAULT      = 2'd2
    } f2d_type_t;

    // Command from decode back to fetch
    typedef enum logic [1:0] {
        D2F_CMD_NONE         = 2'd0,
        D2F_CMD_START_BRANCH = 2'd1,
        D2F_CMD_FLUSH        = 2'd2
    } d2f_cmd_t;

    // Every ROM word is its own byte address XORed with this value
    localparam logic [31:0] ROM_PATTERN = 32'h5A3C_96E1;

endpackage

`default_nettype wire

/* hw/fetch_top.sv */
/*
 * Fetch front end top: fetch unit wired to the behavioral instruction cache
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter int unsigned CACHE_LATENCY = 3,
    parameter int unsigned ROM_WORDS     = 1024
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [31:0] reset_vector,
    input  wire logic        interrupt_pending,
    input  wire logic        dbg_mode,
    output logic             busy,
    output logic             f2d_valid,
    output f2d_type_t        f2d_type,
    output logic [31:0]      f2d_instr,
    output logic [31:0]      f2d_pc,
    input  wire logic        d2f_ready,
    input  d2f_cmd_t         d2f_cmd,
    input  wire logic [31:0] d2f_branchtarget
);

    // Cache handshake between the two blocks
    cache_cmd_t  c_cmd;
    logic [31:0] c_address;
    logic        c_done;
    cache_resp_t c_response;
    logic [31:0] c_load_data;

    fetch_unit u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .reset_vector      (reset_vector),
        .c_done            (c_done),
        .c_response        (c_response),
        .c_load_data       (c_load_data),
        .c_cmd             (c_cmd),
        .c_address         (c_address),
        .interrupt_pending (interrupt_pending),
        .dbg_mode          (dbg_mode),
        .busy              (busy),
        .f2d_valid         (f2d_valid),
        .f2d_type          (f2d_type),
        .f2d_instr         (f2d_instr),
        .f2d_pc            (f2d_pc),
        .d2f_ready         (d2f_ready),
        .d2f_cmd           (d2f_cmd),
        .d2f_branchtarget  (d2f_branchtarget)
    );

    // The latency and depth only matter to the cache model
    instr_rom_cache #(
        .CACHE_LATENCY (CACHE_LATENCY),
        .ROM_WORDS     (ROM_WORDS)
    ) u_cache (
        .clk         (clk),
        .rst_n       (rst_n),
        .c_cmd       (c_cmd),
        .c_address   (c_address),
        .c_done      (c_done),
        .c_response  (c_response),
        .c_load_data (c_load_data)
    );

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
/*
 * Instruction fetch unit: cache command issue, program counter,
 * held word under decode stall, remembered branch and flush
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [31:0] reset_vector,
    // Cache side
    input  wire logic        c_done,
    input  cache_resp_t      c_response,
    input  wire logic [31:0] c_load_data,
    output cache_cmd_t       c_cmd,
    output logic [31:0]      c_address,
    // Status levels
    input  wire logic        interrupt_pending,
    input  wire logic        dbg_mode,
    output logic             busy,
    // Towards decode
    output logic             f2d_valid,
    output f2d_type_t        f2d_type,
    output logic [31:0]      f2d_instr,
    output logic [31:0]      f2d_pc,
    // From decode
    input  wire logic        d2f_ready,
    input  d2f_cmd_t         d2f_cmd,
    input  wire logic [31:0] d2f_branchtarget
);

    //////////////////////////////
    // State registers
    //////////////////////////////

    // The command register follows c_cmd, so it names the command in flight
    cache_cmd_t  active_cmd;
    // The pc follows c_address and stays put while a command is held
    logic [31:0] pc;

    logic        held_valid, held_valid_nxt;
    logic [31:0] held_instr, held_instr_nxt;
    f2d_type_t   held_type, held_type_nxt;

    logic        branched, branched_nxt;
    logic [31:0] branched_target, branched_target_nxt;
    logic        flushed, flushed_nxt;

    //////////////////////////////
    // Decoded conditions
    //////////////////////////////

    logic        active;
    logic        fetch_done;
    logic        idle;
    logic        issue_point;
    logic        branch_now;
    logic        flush_now;
    logic        branching;
    logic        flushing;
    logic [31:0] branching_target;
    logic [31:0] pc_plus_4;
    f2d_type_t   done_type;

    assign active     = active_cmd != CACHE_CMD_NONE;
    assign fetch_done = (active_cmd == CACHE_CMD_EXECUTE) && c_done;
    // Nothing in flight and nothing held, and reset has been released
    assign idle       = rst_n && !active && !held_valid;

    // Decode commands only count while decode is ready
    assign branch_now = d2f_ready && (d2f_cmd == D2F_CMD_START_BRANCH);
    assign flush_now  = d2f_ready && (d2f_cmd == D2F_CMD_FLUSH);

    // A live command is merged with whatever was remembered earlier
    assign branching        = branched || branch_now;
    assign flushing         = flushed || flush_now;
    assign branching_target = branch_now ? d2f_branchtarget : branched_target;
    assign pc_plus_4        = pc + 32'd4;

    assign done_type = (c_response == CACHE_RESP_ACCESS_FAULT) ?
                       F2D_TYPE_ACCESS_FAULT : F2D_TYPE_INSTR;

    // A new command may start when the held word leaves, when the unit is idle,
    // or when the current command finishes and its item (if any) is taken
    assign issue_point = rst_n && ((held_valid && d2f_ready) || idle ||
                         (active && c_done && (d2f_ready || !fetch_done)));

    // Busy while a command runs or a word waits for decode
    assign busy   = active || held_valid;
    assign f2d_pc = pc;

    //////////////////////////////
    // Next state and outputs
    //////////////////////////////

    always_comb begin
        c_cmd               = active_cmd;
        c_address           = pc;
        f2d_valid           = 1'b0;
        f2d_type            = F2D_TYPE_INSTR;
        f2d_instr           = c_load_data;
        held_valid_nxt      = held_valid;
        held_instr_nxt      = held_instr;
        held_type_nxt       = held_type;
        // Anything that arrives now is remembered unless it is served below
        branched_nxt        = branching;
        branched_target_nxt = branching_target;
        flushed_nxt         = flushing;

        // The held word has priority, then a fresh cache answer, then the interrupt
        if (held_valid) begin
            f2d_valid = 1'b1;
            f2d_type  = held_type;
            f2d_instr = held_instr;
        end else if (fetch_done) begin
            f2d_valid = 1'b1;
            f2d_type  = done_type;
        end else if (idle && interrupt_pending) begin
            f2d_valid = 1'b1;
            f2d_type  = F2D_TYPE_INTERRUPT_PENDING;
        end

        // A finished command retires unless a new one replaces it below
        if (active && c_done) begin
            c_cmd = CACHE_CMD_NONE;
        end

        // Decode stalled on a fresh word so it is captured for replay
        if (fetch_done && !d2f_ready) begin
            held_valid_nxt = 1'b1;
            held_instr_nxt = c_load_data;
            held_type_nxt  = done_type;
        end else if (held_valid && d2f_ready) begin
            held_valid_nxt = 1'b0;
        end

        // Debug mode stops issue and a branch beats a flush before the sequential fetch
        if (issue_point && !dbg_mode) begin
            if (branching) begin
                c_cmd        = CACHE_CMD_EXECUTE;
                c_address    = branching_target;
                branched_nxt = 1'b0;
            end else if (flushing) begin
                // The flush keeps the pc, so the stream resumes at pc + 4
                c_cmd       = CACHE_CMD_FLUSH_ALL;
                flushed_nxt = 1'b0;
            end else begin
                c_cmd     = CACHE_CMD_EXECUTE;
                c_address = pc_plus_4;
            end
        end
    end

    // Control state where reset records a pending branch to the reset vector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_cmd      <= CACHE_CMD_NONE;
            held_valid      <= 1'b0;
            branched        <= 1'b1;
            branched_target <= reset_vector;
            flushed         <= 1'b0;
        end else begin
            active_cmd      <= c_cmd;
            held_valid      <= held_valid_nxt;
            branched        <= branched_nxt;
            branched_target <= branched_target_nxt;
            flushed         <= flushed_nxt;
        end
    end

    // Address and held payload
    always_ff @(posedge clk) begin
        pc         <= c_address;
        held_instr <= held_instr_nxt;
        held_type  <= held_type_nxt;
    end

endmodule

`default_nettype wire

/* hw/instr_rom_cache.sv */
/*
 * Behavioral instruction cache: fixed latency countdown, address-derived
 * data words, access fault beyond the ROM depth
 */
`timescale 1ns/100ps
`default_nettype none

module instr_rom_cache import fetch_pkg::*; #(
    parameter int unsigned CACHE_LATENCY = 3,
    parameter int unsigned ROM_WORDS     = 1024
) (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  cache_cmd_t       c_cmd,
    input  wire logic [31:0] c_address,
    output logic             c_done,
    output cache_resp_t      c_response,
    output logic [31:0]      c_load_data
);

    // The counter holds at most CACHE_LATENCY - 1
    localparam int unsigned CNT_W = (CACHE_LATENCY > 1) ? $clog2(CACHE_LATENCY) : 1;
    // First faulting byte address in one extra bit so that a full 4 GiB ROM still fits
    localparam logic [32:0] ROM_LIMIT = 33'(ROM_WORDS) << 2;

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    cache_cmd_t       cmd_q;
    logic [31:0]      addr_q;
    logic             accept;
    logic             out_of_range;

    //////////////////////////////
    // Command capture
    //////////////////////////////

    assign c_done = busy_q && (cnt_q == '0);

    // The finishing cycle counts as idle, so a back-to-back command is taken there
    assign accept = (!busy_q || c_done) && (c_cmd != CACHE_CMD_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            cmd_q  <= CACHE_CMD_NONE;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(CACHE_LATENCY - 1);
            cmd_q  <= c_cmd;
        end else if (c_done) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Address of the captured command
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= c_address;
        end
    end

    //////////////////////////////
    // Answer
    //////////////////////////////

    assign out_of_range = {1'b0, addr_q} >= ROM_LIMIT;

    // Only a fetch can fault and a flush always answers OK
    assign c_response = ((cmd_q == CACHE_CMD_EXECUTE) && out_of_range) ?
                        CACHE_RESP_ACCESS_FAULT : CACHE_RESP_OK;

    // The word is a pure function of the address and reads zero on a fault
    assign c_load_data = (c_response == CACHE_RESP_OK) ? (addr_q ^ ROM_PATTERN) : 32'h0;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the fetch front end testbench with Verilator and runs it.
# Pass or fail is decided by the pass message in the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f all.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/fetch_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
